//--- source/rtcBusPkg.sv
package rtcBusPkg;

    // ------------------------------------------------------------------
    // Chip bus
    // ------------------------------------------------------------------
    localparam int busWidth = 8;

    typedef logic [busWidth-1:0] busByte;
    typedef logic [3:0]          busAddr;

    typedef enum logic [1:0]
    {
        modeInit     = 2'd0,
        modeRead     = 2'd1,
        modeTransfer = 2'd2,
        modeSweep    = 2'd3
    } busMode;

    // Address map of the clock chip
    localparam busAddr addrInit       = 4'd0;
    localparam busAddr addrMode       = 4'd1;
    localparam busAddr addrCommand    = 4'd2;
    localparam busAddr addrDay        = 4'd3;
    localparam busAddr addrMonth      = 4'd4;
    localparam busAddr addrYear       = 4'd5;
    localparam busAddr addrSecond     = 4'd6;
    localparam busAddr addrMinute     = 4'd7;
    localparam busAddr addrHour       = 4'd8;
    localparam busAddr addrLast       = 4'd11;
    localparam busAddr addrCommandEnd = 4'd12;

    localparam busByte commandByte = 8'hF0;

    // ------------------------------------------------------------------
    // Slot timing
    // ------------------------------------------------------------------
    localparam int phaseWidth = 5;
    localparam int turnPhase  = 11;
    localparam int readFirst  = 26;
    localparam int readLast   = 30;

    // Transfer sequence lengths and driven lead-in
    localparam int longSteps  = 20;
    localparam int shortSteps = 17;
    localparam int longHold   = 10;
    localparam int shortHold  = 6;

endpackage

//--- source/rtcSequencer.sv
module rtcSequencer
(
    input  logic               reloj,
    input  logic               resetM,
    input  logic               sync,
    input  logic               slotStep,
    input  rtcBusPkg::busMode  mode,
    input  logic [2:0]         status,
    output rtcBusPkg::busAddr  busAddress,
    output logic [4:0]         transferStep
);

    // First part of each transfer sequence, starting at the day byte
    localparam int longSplit  = rtcBusPkg::addrCommandEnd - rtcBusPkg::addrDay + 1;
    localparam int shortSplit = rtcBusPkg::addrHour - rtcBusPkg::addrDay + 1;

    rtcBusPkg::busAddr readCount;
    rtcBusPkg::busAddr sweepCount;
    logic [4:0]        longIndex;
    logic [4:0]        shortIndex;
    logic              shortForm;
    rtcBusPkg::busAddr longAddr;
    rtcBusPkg::busAddr shortAddr;
    logic              restart;

    assign restart   = resetM | sync;
    assign shortForm = (status == 3'd1) || (status == 3'd3);

    // ------------------------------------------------------------------
    // Slot counters
    // ------------------------------------------------------------------
    always_ff @(posedge reloj)
    begin
        if (restart)
        begin
            readCount <= rtcBusPkg::addrCommand;
        end
        else if (slotStep)
        begin
            if (readCount == rtcBusPkg::addrLast)
                readCount <= rtcBusPkg::addrCommand;
            else
                readCount <= readCount + 4'd1;
        end
    end

    always_ff @(posedge reloj)
    begin
        if (restart)
        begin
            sweepCount <= rtcBusPkg::addrMode;
        end
        else if (slotStep)
        begin
            if (sweepCount == rtcBusPkg::addrLast)
                sweepCount <= rtcBusPkg::addrMode;
            else
                sweepCount <= sweepCount + 4'd1;
        end
    end

    always_ff @(posedge reloj)
    begin
        if (restart)
        begin
            longIndex <= 5'd0;
        end
        else if (slotStep)
        begin
            if (longIndex == rtcBusPkg::longSteps - 1)
                longIndex <= 5'd0;
            else
                longIndex <= longIndex + 5'd1;
        end
    end

    always_ff @(posedge reloj)
    begin
        if (restart)
        begin
            shortIndex <= 5'd0;
        end
        else if (slotStep)
        begin
            if (shortIndex == rtcBusPkg::shortSteps - 1)
                shortIndex <= 5'd0;
            else
                shortIndex <= shortIndex + 5'd1;
        end
    end

    // ------------------------------------------------------------------
    // Transfer index to address
    // ------------------------------------------------------------------
    // Long: 3..12 then 2..11
    always_comb
    begin
        if (longIndex < longSplit)
            longAddr = rtcBusPkg::addrDay + rtcBusPkg::busAddr'(longIndex);
        else
            longAddr = rtcBusPkg::addrCommand + rtcBusPkg::busAddr'(longIndex - longSplit);
    end

    // Short: 3..8, command end, then 2..11
    always_comb
    begin
        if (shortIndex < shortSplit)
            shortAddr = rtcBusPkg::addrDay + rtcBusPkg::busAddr'(shortIndex);
        else if (shortIndex == shortSplit)
            shortAddr = rtcBusPkg::addrCommandEnd;
        else
            shortAddr = rtcBusPkg::addrCommand
                      + rtcBusPkg::busAddr'(shortIndex - shortSplit - 1);
    end

    assign transferStep = shortForm ? shortIndex : longIndex;

    always_comb
    begin
        case (mode)
            rtcBusPkg::modeInit:     busAddress = rtcBusPkg::addrInit;
            rtcBusPkg::modeRead:     busAddress = readCount;
            rtcBusPkg::modeTransfer: busAddress = shortForm ? shortAddr : longAddr;
            rtcBusPkg::modeSweep:    busAddress = sweepCount;
            default:                 busAddress = rtcBusPkg::addrInit;
        endcase
    end

endmodule

//--- source/rtcBusDriver.sv
module rtcBusDriver
(
    input  logic                                reloj,
    input  logic                                resetM,
    input  logic                                slotStep,
    input  rtcBusPkg::busMode                   mode,
    input  logic [2:0]                          status,
    input  rtcBusPkg::busAddr                   busAddress,
    input  logic [rtcBusPkg::phaseWidth-1:0]    slotPhase,
    input  rtcBusPkg::busByte                   initWord,
    input  rtcBusPkg::busByte                   modeWord,
    input  rtcBusPkg::busByte                   dayOut,
    input  rtcBusPkg::busByte                   monthOut,
    input  rtcBusPkg::busByte                   yearOut,
    input  rtcBusPkg::busByte                   secondOut,
    input  rtcBusPkg::busByte                   minuteOut,
    input  rtcBusPkg::busByte                   hourOut,
    inout  wire rtcBusPkg::busByte              busData,
    output logic                                busRelease,
    output logic                                readStrobe
);

    rtcBusPkg::busByte outByte;
    logic [4:0]        holdStep;
    logic              shortForm;
    logic              lateHalf;
    logic              inHold;

    assign shortForm = (status == 3'd1) || (status == 3'd3);

    // ------------------------------------------------------------------
    // Output byte select
    // ------------------------------------------------------------------
    always_comb
    begin
        case (busAddress)
            rtcBusPkg::addrInit:       outByte = initWord;
            rtcBusPkg::addrMode:       outByte = modeWord;
            rtcBusPkg::addrCommand:    outByte = rtcBusPkg::commandByte;
            rtcBusPkg::addrCommandEnd: outByte = rtcBusPkg::commandByte;
            rtcBusPkg::addrDay:        outByte = dayOut;
            rtcBusPkg::addrMonth:      outByte = monthOut;
            rtcBusPkg::addrYear:       outByte = yearOut;
            rtcBusPkg::addrSecond:     outByte = secondOut;
            rtcBusPkg::addrMinute:     outByte = minuteOut;
            rtcBusPkg::addrHour:       outByte = hourOut;
            // Chronometer slots carry nothing
            default:                   outByte = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Transfer hold counter
    // ------------------------------------------------------------------
    // Free of sync, so the lead-in restarts only on a mode change
    always_ff @(posedge reloj)
    begin
        if (resetM || (mode != rtcBusPkg::modeTransfer))
        begin
            holdStep <= 5'd0;
        end
        else if (slotStep)
        begin
            if (shortForm && (holdStep >= rtcBusPkg::shortSteps - 1))
                holdStep <= 5'd0;
            else if (!shortForm && (holdStep >= rtcBusPkg::longSteps - 1))
                holdStep <= 5'd0;
            else
                holdStep <= holdStep + 5'd1;
        end
    end

    assign inHold = shortForm ? (holdStep < rtcBusPkg::shortHold)
                              : (holdStep < rtcBusPkg::longHold);

    // ------------------------------------------------------------------
    // Direction and read strobe
    // ------------------------------------------------------------------
    assign lateHalf = slotPhase > rtcBusPkg::turnPhase;

    always_comb
    begin
        case (mode)
            rtcBusPkg::modeInit:     busRelease = 1'b0;
            rtcBusPkg::modeRead:     busRelease = lateHalf;
            rtcBusPkg::modeTransfer: busRelease = !inHold && lateHalf;
            rtcBusPkg::modeSweep:    busRelease = (busAddress != rtcBusPkg::addrMode) && lateHalf;
            default:                 busRelease = 1'b0;
        endcase
    end

    assign readStrobe = busRelease
                     && (slotPhase >= rtcBusPkg::readFirst)
                     && (slotPhase <= rtcBusPkg::readLast);

    assign busData = busRelease ? 'z : outByte;

endmodule

//--- source/rtcCaptureBank.sv
module rtcCaptureBank
(
    input  logic               reloj,
    input  logic               resetM,
    input  logic               readStrobe,
    input  logic               latchEnable,
    input  rtcBusPkg::busMode  mode,
    input  rtcBusPkg::busAddr  busAddress,
    input  rtcBusPkg::busByte  busData,
    output rtcBusPkg::busByte  dayIn,
    output rtcBusPkg::busByte  monthIn,
    output rtcBusPkg::busByte  yearIn,
    output rtcBusPkg::busByte  secondIn,
    output rtcBusPkg::busByte  minuteIn,
    output rtcBusPkg::busByte  hourIn
);

    localparam int timeCount = rtcBusPkg::addrHour - rtcBusPkg::addrDay + 1;

    rtcBusPkg::busByte timeReg [timeCount];
    logic [2:0]        slotIndex;
    logic              inRange;
    logic              latchOk;
    logic              captureHit;

    // ------------------------------------------------------------------
    // Demux select
    // ------------------------------------------------------------------
    assign inRange = (busAddress >= rtcBusPkg::addrDay) && (busAddress <= rtcBusPkg::addrHour);

    // Transfer reads only land with the external latch enable
    assign latchOk = (mode != rtcBusPkg::modeTransfer) || latchEnable;

    assign captureHit = readStrobe && inRange && latchOk;
    assign slotIndex  = 3'(busAddress - rtcBusPkg::addrDay);

    // ------------------------------------------------------------------
    // Date/time registers
    // ------------------------------------------------------------------
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            for (int i = 0; i < timeCount; i++)
            begin
                timeReg[i] <= '0;
            end
        end
        else if (captureHit)
        begin
            timeReg[slotIndex] <= busData;
        end
    end

    assign dayIn    = timeReg[0];
    assign monthIn  = timeReg[1];
    assign yearIn   = timeReg[2];
    assign secondIn = timeReg[3];
    assign minuteIn = timeReg[4];
    assign hourIn   = timeReg[5];

endmodule

//--- source/rtcBusTop.sv
module rtcBusTop
(
    input  logic                                reloj,
    input  logic                                resetM,
    input  logic                                sync,
    input  logic                                slotStep,
    input  logic [rtcBusPkg::phaseWidth-1:0]    slotPhase,
    input  rtcBusPkg::busMode                   mode,
    input  logic [2:0]                          status,
    input  logic                                latchEnable,
    input  rtcBusPkg::busByte                   initWord,
    input  rtcBusPkg::busByte                   modeWord,
    input  rtcBusPkg::busByte                   dayOut,
    input  rtcBusPkg::busByte                   monthOut,
    input  rtcBusPkg::busByte                   yearOut,
    input  rtcBusPkg::busByte                   secondOut,
    input  rtcBusPkg::busByte                   minuteOut,
    input  rtcBusPkg::busByte                   hourOut,
    inout  wire rtcBusPkg::busByte              busData,
    output rtcBusPkg::busAddr                   busAddress,
    output logic                                readStrobe,
    output rtcBusPkg::busByte                   dayIn,
    output rtcBusPkg::busByte                   monthIn,
    output rtcBusPkg::busByte                   yearIn,
    output rtcBusPkg::busByte                   secondIn,
    output rtcBusPkg::busByte                   minuteIn,
    output rtcBusPkg::busByte                   hourIn
);

    logic busRelease;

    rtcSequencer i_sequencer
    (
        .reloj        (reloj),
        .resetM       (resetM),
        .sync         (sync),
        .slotStep     (slotStep),
        .mode         (mode),
        .status       (status),
        .busAddress   (busAddress),
        .transferStep ()
    );

    rtcBusDriver i_driver
    (
        .reloj      (reloj),
        .resetM     (resetM),
        .slotStep   (slotStep),
        .mode       (mode),
        .status     (status),
        .busAddress (busAddress),
        .slotPhase  (slotPhase),
        .initWord   (initWord),
        .modeWord   (modeWord),
        .dayOut     (dayOut),
        .monthOut   (monthOut),
        .yearOut    (yearOut),
        .secondOut  (secondOut),
        .minuteOut  (minuteOut),
        .hourOut    (hourOut),
        .busData    (busData),
        .busRelease (busRelease),
        .readStrobe (readStrobe)
    );

    rtcCaptureBank i_capture
    (
        .reloj       (reloj),
        .resetM      (resetM),
        .readStrobe  (readStrobe),
        .latchEnable (latchEnable),
        .mode        (mode),
        .busAddress  (busAddress),
        .busData     (busData),
        .dayIn       (dayIn),
        .monthIn     (monthIn),
        .yearIn      (yearIn),
        .secondIn    (secondIn),
        .minuteIn    (minuteIn),
        .hourIn      (hourIn)
    );

endmodule

//--- tb/rtcBus_assertions.sv
module rtcBusAssertions
(
    input  logic                                reloj,
    input  logic                                resetM,
    input  logic                                readStrobe,
    input  logic                                busRelease,
    input  rtcBusPkg::busMode                   mode,
    input  logic [rtcBusPkg::phaseWidth-1:0]    slotPhase,
    input  rtcBusPkg::busAddr                   busAddress
);

    // Strobe only while the chip owns the bus
    strobeReleased: assert property (@(posedge reloj)
        readStrobe |-> busRelease
                    && (slotPhase > rtcBusPkg::turnPhase)
                    && (mode != rtcBusPkg::modeInit)
                    && !((mode == rtcBusPkg::modeSweep)
                         && (busAddress == rtcBusPkg::addrMode)))
    else
        $error("readStrobe high while the bus is still driven");

    addrInMap: assert property (@(posedge reloj) busAddress <= rtcBusPkg::addrCommandEnd)
    else
        $error("busAddress beyond the chip address map");

    quietAfterReset: assert property (@(posedge reloj) resetM |=> !readStrobe)
    else
        $error("readStrobe high in the cycle after reset");

endmodule

bind rtcBusTop rtcBusAssertions i_assertions
(
    .reloj      (reloj),
    .resetM     (resetM),
    .readStrobe (readStrobe),
    .busRelease (busRelease),
    .mode       (mode),
    .slotPhase  (slotPhase),
    .busAddress (busAddress)
);

//--- tb/rtcBusTb.sv
module rtcBusTb;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 10;
    localparam int slotLength  = 32;
    localparam int noCapture   = 6;

    typedef struct
    {
        string             name;
        rtcBusPkg::busMode mode;
        logic [2:0]        status;
        logic              latch;
        logic              step;
        logic              syncPulse;
        logic [4:0]        phase;
        rtcBusPkg::busByte offer;
        rtcBusPkg::busAddr expAddr;
        logic              expDrive;
        logic              expStrobe;
        int                capIdx;
    } testRow;

    logic              reloj = 1'b0;
    logic              resetM;
    logic              sync;
    logic              slotStep;
    logic [4:0]        slotPhase;
    rtcBusPkg::busMode mode;
    logic [2:0]        status;
    logic              latchEnable;
    rtcBusPkg::busByte initWord;
    rtcBusPkg::busByte modeWord;
    rtcBusPkg::busByte dayOut;
    rtcBusPkg::busByte monthOut;
    rtcBusPkg::busByte yearOut;
    rtcBusPkg::busByte secondOut;
    rtcBusPkg::busByte minuteOut;
    rtcBusPkg::busByte hourOut;
    wire rtcBusPkg::busByte busData;
    rtcBusPkg::busAddr busAddress;
    logic              readStrobe;
    rtcBusPkg::busByte dayIn;
    rtcBusPkg::busByte monthIn;
    rtcBusPkg::busByte yearIn;
    rtcBusPkg::busByte secondIn;
    rtcBusPkg::busByte minuteIn;
    rtcBusPkg::busByte hourIn;

    rtcBusPkg::busByte offerByte;
    logic              offerOn;
    rtcBusPkg::busByte expectedCapture [6];
    testRow            rows [$];
    integer            seed = 32'h8cd0c18d;
    logic              tableReady = 1'b0;

    always #(clockPeriod / 2) reloj = ~reloj;

    // Chip side of the bus, only while the DUT lets go
    assign busData = offerOn ? offerByte : 'z;

    rtcBusTop i_dut (.*);

    // ------------------------------------------------------------------
    // Expected values from the bus rules
    // ------------------------------------------------------------------
    function automatic rtcBusPkg::busByte busByteFor(input int addr);
        case (addr)
            0:       return initWord;
            1:       return modeWord;
            2, 12:   return 8'hF0;
            3:       return dayOut;
            4:       return monthOut;
            5:       return yearOut;
            6:       return secondOut;
            7:       return minuteOut;
            8:       return hourOut;
            default: return 8'h00;
        endcase
    endfunction

    task automatic addRow(input string name, input rtcBusPkg::busMode rowMode,
                          input logic [2:0] rowStatus, input logic latch, input logic step,
                          input logic syncPulse, input int phase, input int addr,
                          input logic hold);
        testRow r;
        r.name      = name;
        r.mode      = rowMode;
        r.status    = rowStatus;
        r.latch     = latch;
        r.step      = step;
        r.syncPulse = syncPulse;
        r.phase     = 5'(phase);
        r.offer     = 8'($random(seed));
        r.expAddr   = rtcBusPkg::busAddr'(addr);
        r.expDrive  = (rowMode == rtcBusPkg::modeInit) || hold || (phase <= 11)
                   || ((rowMode == rtcBusPkg::modeSweep) && (addr == 1));
        r.expStrobe = !r.expDrive && (phase >= 26) && (phase <= 30);
        r.capIdx    = noCapture;
        if (r.expStrobe && (addr >= 3) && (addr <= 8)
            && ((rowMode != rtcBusPkg::modeTransfer) || latch))
            r.capIdx = addr - 3;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        addRow("initIdle", rtcBusPkg::modeInit, 3'd0, 1'b0, 1'b0, 1'b0, 28, 0, 1'b0);
        // Read sweep 2..11 with turnaround edges
        addRow("readTurn", rtcBusPkg::modeRead, 3'd0, 1'b0, 1'b0, 1'b0, 12, 2, 1'b0);
        addRow("readLate", rtcBusPkg::modeRead, 3'd0, 1'b0, 1'b0, 1'b0, 31, 2, 1'b0);
        for (int a = 2; a <= 11; a++)
        begin
            addRow($sformatf("read%0dDrive", a), rtcBusPkg::modeRead, 3'd0, 1'b0, 1'b0, 1'b0,
                   11, a, 1'b0);
            addRow($sformatf("read%0dStrobe", a), rtcBusPkg::modeRead, 3'd0, 1'b0, 1'b1, 1'b0,
                   26 + a % 5, a, 1'b0);
        end
        addRow("readWrapSync", rtcBusPkg::modeRead, 3'd0, 1'b0, 1'b0, 1'b1, 0, 2, 1'b0);
        // Long transfer, one latched read at the second byte
        for (int i = 0; i < 20; i++)
            addRow($sformatf("long%0d", i), rtcBusPkg::modeTransfer, 3'd0, i == 14, 1'b1, 1'b0,
                   28, (i < 10) ? 3 + i : i - 8, i < 10);
        addRow("longWrapSync", rtcBusPkg::modeTransfer, 3'd0, 1'b0, 1'b0, 1'b1, 28, 3, 1'b1);
        // Short transfer
        for (int i = 0; i < 17; i++)
            addRow($sformatf("short%0d", i), rtcBusPkg::modeTransfer, 3'd3, 1'b0, 1'b1, 1'b0,
                   28, (i < 6) ? 3 + i : ((i == 6) ? 12 : i - 5), i < 6);
        addRow("shortWrapSync", rtcBusPkg::modeTransfer, 3'd3, 1'b0, 1'b0, 1'b1, 28, 3, 1'b1);
        // Full sweep 1..11, then a sync mid-sequence
        addRow("sweepModeLate", rtcBusPkg::modeSweep, 3'd0, 1'b0, 1'b0, 1'b0, 31, 1, 1'b0);
        for (int a = 1; a <= 11; a++)
            addRow($sformatf("sweep%0d", a), rtcBusPkg::modeSweep, 3'd0, 1'b0, 1'b1, 1'b0,
                   28, a, 1'b0);
        addRow("sweepWrap", rtcBusPkg::modeSweep, 3'd0, 1'b0, 1'b1, 1'b0, 20, 1, 1'b0);
        addRow("sweepSync", rtcBusPkg::modeSweep, 3'd0, 1'b0, 1'b1, 1'b1, 28, 2, 1'b0);
        addRow("sweepAfterSync", rtcBusPkg::modeSweep, 3'd0, 1'b0, 1'b0, 1'b0, 5, 1, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic checkValue(input string testName, input string field,
                              input logic [7:0] expected, input logic [7:0] actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch %s %s expected %h actual %h", testName, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic checkCaptures(input string testName);
        rtcBusPkg::busByte captured [6];
        string             fields [6];
        captured = '{dayIn, monthIn, yearIn, secondIn, minuteIn, hourIn};
        fields   = '{"dayIn", "monthIn", "yearIn", "secondIn", "minuteIn", "hourIn"};
        for (int k = 0; k < 6; k++)
        begin
            checkValue(testName, fields[k], expectedCapture[k], captured[k]);
        end
    endtask

    task automatic checkRow(input testRow r);
        rtcBusPkg::busByte expData;
        expData = r.expDrive ? busByteFor(r.expAddr) : r.offer;
        checkValue(r.name, "busAddress", 8'(r.expAddr), 8'(busAddress));
        checkValue(r.name, "busData", expData, busData);
        checkValue(r.name, "readStrobe", 8'(r.expStrobe), 8'(readStrobe));
        checkCaptures(r.name);
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial
    begin
        resetM      = 1'b1;
        sync        = 1'b0;
        slotStep    = 1'b0;
        slotPhase   = 5'd0;
        mode        = rtcBusPkg::modeInit;
        status      = 3'd0;
        latchEnable = 1'b0;
        offerByte   = 8'h00;
        offerOn     = 1'b0;
        initWord    = 8'($random(seed));
        modeWord    = 8'($random(seed));
        dayOut      = 8'($random(seed));
        monthOut    = 8'($random(seed));
        yearOut     = 8'($random(seed));
        secondOut   = 8'($random(seed));
        minuteOut   = 8'($random(seed));
        hourOut     = 8'($random(seed));
        expectedCapture = '{default: 8'h00};
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge reloj);
        resetM <= 1'b0;
        foreach (rows[i])
        begin
            @(posedge reloj);
            mode        <= rows[i].mode;
            status      <= rows[i].status;
            latchEnable <= rows[i].latch;
            slotStep    <= rows[i].step;
            sync        <= rows[i].syncPulse;
            slotPhase   <= rows[i].phase;
            offerByte   <= rows[i].offer;
            offerOn     <= !rows[i].expDrive;
            @(negedge reloj);
            checkRow(rows[i]);
            // Lands on the next edge
            if (rows[i].capIdx != noCapture)
                expectedCapture[rows[i].capIdx] = rows[i].offer;
        end
        @(posedge reloj);
        slotStep <= 1'b0;
        sync     <= 1'b0;
        offerOn  <= 1'b0;
        mode     <= rtcBusPkg::modeInit;
        @(negedge reloj);
        checkCaptures("final");
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial
    begin
        int limit;
        wait (tableReady);
        limit = (rows.size() * slotLength + resetCycles + 20) * clockPeriod;
        #(limit);
        $display("watchdog timeout, the test rows did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- tb.f
source/rtcBusPkg.sv
source/rtcSequencer.sv
source/rtcBusDriver.sv
source/rtcCaptureBank.sv
source/rtcBusTop.sv
tb/rtcBus_assertions.sv
tb/rtcBusTb.sv
